//--- design/fix_session_macros.svh
//////////////////////////////////////////////////
// FIX session layer widths and codes
// host count, launcher depth, validity and
// message-type encodings shared by RTL and bench
//////////////////////////////////////////////////

`ifndef FIX_SESSION_MACROS_SVH
`define FIX_SESSION_MACROS_SVH

// field widths
`define FIX_HOST_BITS       3
`define FIX_NUM_HOSTS       (1 << `FIX_HOST_BITS)
`define FIX_COMP_ID_BITS    64
`define FIX_COMP_LEN_BITS   4
`define FIX_MSG_BITS        4
`define FIX_VAL_BITS        3

`define FIX_LAUNCH_DEPTH    4    // outgoing order queue

// validity from the receive processor
`define FIX_VAL_VALID       3'd0
`define FIX_VAL_GARBLED     3'd1
`define FIX_VAL_SEQ_HIGH    3'd2    // gap, peer ahead of us
`define FIX_VAL_SEQ_LOW     3'd3
`define FIX_VAL_INVALID     3'd4

// message types, in and out
`define FIX_MSG_LOGON       4'd1
`define FIX_MSG_LOGOUT      4'd2
`define FIX_MSG_HEARTBEAT   4'd3
`define FIX_MSG_RESEND_REQ  4'd4
`define FIX_MSG_GAP_FILL    4'd5
`define FIX_MSG_SEQ_RESET   4'd6
`define FIX_MSG_APP         4'd15   // anything not session level

`endif

//--- design/fix_session_pkg.sv
//////////////////////////////////////////////////
// FIX session layer types
// field typedefs and the per-host session states
//////////////////////////////////////////////////

`default_nettype none

`include "fix_session_macros.svh"

package fix_session_pkg;

	// host index into the config and session tables
	typedef logic [`FIX_HOST_BITS-1:0] host_t;

	// target company id, left aligned bytes
	typedef logic [`FIX_COMP_ID_BITS-1:0] comp_id_t;

	typedef logic [`FIX_COMP_LEN_BITS-1:0] comp_len_t;   // valid id bytes

	typedef logic [`FIX_MSG_BITS-1:0] msg_code_t;
	typedef logic [`FIX_VAL_BITS-1:0] validity_t;

	// per-host session state
	typedef enum logic [2:0] {
		SES_DISCONNECTED   = 3'd0,
		SES_CONNECTED      = 3'd1,   // acceptor waiting for logon
		SES_LOGON_SENT     = 3'd2,   // initiator waiting for logon reply
		SES_NORMAL         = 3'd3,
		SES_HEARTBEAT_SENT = 3'd4,
		SES_LOGOUT_SENT    = 3'd5,
		SES_RESEND_SENT    = 3'd6,
		SES_RESEND_LOGOUT  = 3'd7    // resend pending, logout after it
	} session_state_e;

endpackage

`default_nettype wire

//--- design/host_config_table.sv
//////////////////////////////////////////////////
// host configuration table
// per-host target id, id length and role, one
// write port, two combinational read ports
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "fix_session_macros.svh"

module host_config_table
	import fix_session_pkg::*;
(
	input  wire logic      clk,
	input  wire logic      rst,

	// configuration write
	input  wire logic      cfg_we_i,
	input  wire host_t     cfg_host_i,
	input  wire comp_id_t  cfg_comp_id_i,
	input  wire comp_len_t cfg_comp_len_i,
	input  wire logic      cfg_initiator_i,

	// port A, role lookup for the session machine
	input  wire host_t     rd_a_host_i,
	output logic           rd_a_initiator_o,

	// port B, addressing for the launcher
	input  wire host_t     rd_b_host_i,
	output comp_id_t       rd_b_comp_id_o,
	output comp_len_t      rd_b_comp_len_o
);

	localparam int NUM_HOSTS = `FIX_NUM_HOSTS;

	comp_id_t  comp_id_q   [NUM_HOSTS];
	comp_len_t comp_len_q  [NUM_HOSTS];
	logic      initiator_q [NUM_HOSTS];   // 1 = we open the session

	always_ff @(posedge clk) begin
		if (rst) begin
			// every host comes up as acceptor with no id
			for (int h = 0; h < NUM_HOSTS; h++) begin
				comp_id_q[h]   <= '0;
				comp_len_q[h]  <= '0;
				initiator_q[h] <= 1'b0;
			end
		end else if (cfg_we_i) begin
			comp_id_q[cfg_host_i]   <= cfg_comp_id_i;
			comp_len_q[cfg_host_i]  <= cfg_comp_len_i;
			initiator_q[cfg_host_i] <= cfg_initiator_i;
		end
	end

	assign rd_a_initiator_o = initiator_q[rd_a_host_i];

	assign rd_b_comp_id_o  = comp_id_q[rd_b_host_i];
	assign rd_b_comp_len_o = comp_len_q[rd_b_host_i];

endmodule

`default_nettype wire

//--- design/session_fsm.sv
//////////////////////////////////////////////////
// session state machine
// one state per host, updated by message, connect,
// end-of-session, timeout and resend-done events
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "fix_session_macros.svh"

module session_fsm
	import fix_session_pkg::*;
(
	input  wire logic      clk,
	input  wire logic      rst,

	// events, at most one per cycle
	input  wire logic      new_message_i,
	input  wire msg_code_t msg_type_i,
	input  wire validity_t validity_i,
	input  wire logic      connected_i,
	input  wire logic      end_session_i,
	input  wire logic      timeout_i,
	input  wire logic      resend_done_i,
	input  wire host_t     host_i,

	// role lookup in the config table
	output host_t          cfg_host_o,
	input  wire logic      cfg_initiator_i,

	// actions
	output logic           disconnect_o,
	output host_t          disconnect_host_o,
	output logic           ignore_o,
	output logic           update_seq_o,
	output host_t          seq_host_o,

	// outgoing message orders
	output logic           req_valid_o,
	output host_t          req_host_o,
	output msg_code_t      req_code_o
);

	localparam int NUM_HOSTS = `FIX_NUM_HOSTS;

	session_state_e state_q [NUM_HOSTS];
	session_state_e cur_state;
	session_state_e state_d;

	logic      any_event;
	logic      msg_valid;
	logic      msg_seq_high;
	logic      dis_c;
	logic      ign_c;
	logic      upd_c;
	logic      req_c;
	msg_code_t code_c;

	assign cfg_host_o = host_i;   // role of the host the event is for

	assign any_event = new_message_i | connected_i | end_session_i |
		timeout_i | resend_done_i;

	assign msg_valid    = (validity_i == `FIX_VAL_VALID);
	assign msg_seq_high = (validity_i == `FIX_VAL_SEQ_HIGH);

	always_comb begin
		cur_state = state_q[host_i];
		state_d   = cur_state;
		dis_c     = 1'b0;
		ign_c     = 1'b0;
		upd_c     = 1'b0;
		req_c     = 1'b0;
		code_c    = `FIX_MSG_HEARTBEAT;

		if (new_message_i) begin
			// nothing to do for a host without a session
			if (cur_state != SES_DISCONNECTED) begin
				if (validity_i == `FIX_VAL_SEQ_LOW || validity_i == `FIX_VAL_INVALID) begin
					dis_c = 1'b1;
				end else if (validity_i == `FIX_VAL_GARBLED) begin
					ign_c = 1'b1;   // drop it, state stays
				end else begin
					case (cur_state)
						SES_CONNECTED: begin
							if (msg_type_i == `FIX_MSG_LOGON && msg_valid) begin
								req_c   = 1'b1;   // answer the logon
								code_c  = `FIX_MSG_LOGON;
								state_d = SES_NORMAL;
							end else begin
								dis_c = 1'b1;
							end
						end
						SES_LOGON_SENT: begin
							if (msg_type_i == `FIX_MSG_LOGON && msg_valid) begin
								state_d = SES_NORMAL;
							end else if (msg_type_i == `FIX_MSG_LOGON && msg_seq_high) begin
								req_c   = 1'b1;
								code_c  = `FIX_MSG_RESEND_REQ;
								state_d = SES_RESEND_SENT;
							end else begin
								dis_c = 1'b1;
							end
						end
						SES_NORMAL, SES_HEARTBEAT_SENT: begin
							if (msg_type_i == `FIX_MSG_LOGOUT && msg_valid) begin
								req_c  = 1'b1;   // confirm logout, then drop
								code_c = `FIX_MSG_LOGOUT;
								dis_c  = 1'b1;
							end else if (msg_type_i == `FIX_MSG_LOGOUT && msg_seq_high) begin
								req_c   = 1'b1;
								code_c  = `FIX_MSG_RESEND_REQ;
								state_d = SES_RESEND_LOGOUT;
							end else if (msg_seq_high) begin
								req_c   = 1'b1;
								code_c  = `FIX_MSG_RESEND_REQ;
								state_d = SES_RESEND_SENT;
							end else if (msg_type_i == `FIX_MSG_HEARTBEAT) begin
								req_c   = 1'b1;
								code_c  = `FIX_MSG_HEARTBEAT;
								state_d = SES_HEARTBEAT_SENT;
							end else begin
								state_d = SES_NORMAL;
							end
						end
						SES_LOGOUT_SENT: begin
							dis_c = 1'b1;   // logout reply or not, session ends
						end
						SES_RESEND_SENT, SES_RESEND_LOGOUT: begin
							if (msg_type_i == `FIX_MSG_GAP_FILL ||
								msg_type_i == `FIX_MSG_SEQ_RESET) begin
								upd_c = 1'b1;
							end else if (msg_seq_high) begin
								req_c  = 1'b1;   // still behind, ask again
								code_c = `FIX_MSG_RESEND_REQ;
							end
						end
						default: begin
							state_d = cur_state;
						end
					endcase
				end
			end
		end else if (connected_i) begin
			if (cfg_initiator_i) begin
				req_c   = 1'b1;
				code_c  = `FIX_MSG_LOGON;
				state_d = SES_LOGON_SENT;
			end else begin
				state_d = SES_CONNECTED;   // wait for peer logon
			end
		end else if (end_session_i) begin
			req_c   = 1'b1;
			code_c  = `FIX_MSG_LOGOUT;
			state_d = SES_LOGOUT_SENT;
		end else if (timeout_i) begin
			if (cur_state == SES_LOGON_SENT || cur_state == SES_LOGOUT_SENT ||
				cur_state == SES_HEARTBEAT_SENT) begin
				dis_c = 1'b1;   // peer did not answer in time
			end else if (cur_state != SES_DISCONNECTED) begin
				req_c   = 1'b1;
				code_c  = `FIX_MSG_HEARTBEAT;
				state_d = SES_HEARTBEAT_SENT;
			end
		end else if (resend_done_i) begin
			if (cur_state == SES_RESEND_SENT) begin
				state_d = SES_NORMAL;
			end else if (cur_state == SES_RESEND_LOGOUT) begin
				req_c   = 1'b1;
				code_c  = `FIX_MSG_LOGOUT;
				state_d = SES_LOGOUT_SENT;
			end
		end

		if (dis_c) begin
			state_d = SES_DISCONNECTED;
		end
	end

	// session state table
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int h = 0; h < NUM_HOSTS; h++) begin
				state_q[h] <= SES_DISCONNECTED;
			end
		end else if (any_event) begin
			state_q[host_i] <= state_d;
		end
	end

	// action strobes, one cycle after the event
	always_ff @(posedge clk) begin
		if (rst) begin
			disconnect_o <= 1'b0;
			ignore_o     <= 1'b0;
			update_seq_o <= 1'b0;
			req_valid_o  <= 1'b0;
		end else begin
			disconnect_o <= dis_c;
			ignore_o     <= ign_c;
			update_seq_o <= upd_c;
			req_valid_o  <= req_c;
		end
	end

	always_ff @(posedge clk) begin
		if (dis_c) disconnect_host_o <= host_i;
		if (upd_c) seq_host_o <= host_i;
		if (req_c) begin
			req_host_o <= host_i;
			req_code_o <= code_c;
		end
	end

endmodule

`default_nettype wire

//--- design/message_launcher.sv
//////////////////////////////////////////////////
// message launcher
// queues outgoing session orders while the builder
// is busy, adds the target id when issuing
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "fix_session_macros.svh"

module message_launcher
	import fix_session_pkg::*;
(
	input  wire logic      clk,
	input  wire logic      rst,

	input  wire logic      req_valid_i,
	input  wire host_t     req_host_i,
	input  wire msg_code_t req_code_i,
	input  wire logic      msg_busy_i,    // builder level, holds the queue

	// target lookup for the head entry
	output host_t          cfg_host_o,
	input  wire comp_id_t  cfg_comp_id_i,
	input  wire comp_len_t cfg_comp_len_i,

	output logic           initiate_msg_o,
	output msg_code_t      msg_code_o,
	output comp_id_t       target_comp_id_o,
	output comp_len_t      target_comp_len_o,
	output logic           launch_drop_o
);

	localparam int DEPTH = `FIX_LAUNCH_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	host_t     host_mem [DEPTH];
	msg_code_t code_mem [DEPTH];

	// extra msb tells full from empty
	logic [PTR_W:0] wr_ptr;
	logic [PTR_W:0] rd_ptr;
	logic [PTR_W:0] count;
	logic           full;
	logic           empty;
	logic           push;
	logic           pop;

	assign count = wr_ptr - rd_ptr;
	assign full  = (count == (PTR_W+1)'(DEPTH));
	assign empty = (count == '0);

	assign push = req_valid_i & ~full;
	assign pop  = ~empty & ~msg_busy_i;

	assign cfg_host_o = host_mem[rd_ptr[PTR_W-1:0]];

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr         <= '0;
			rd_ptr         <= '0;
			initiate_msg_o <= 1'b0;
			launch_drop_o  <= 1'b0;
		end else begin
			if (push) wr_ptr <= wr_ptr + 1'b1;
			if (pop) rd_ptr <= rd_ptr + 1'b1;
			initiate_msg_o <= pop;
			launch_drop_o  <= req_valid_i & full;   // queue overflow
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			host_mem[wr_ptr[PTR_W-1:0]] <= req_host_i;
			code_mem[wr_ptr[PTR_W-1:0]] <= req_code_i;
		end
		if (pop) begin
			msg_code_o        <= code_mem[rd_ptr[PTR_W-1:0]];
			target_comp_id_o  <= cfg_comp_id_i;
			target_comp_len_o <= cfg_comp_len_i;
		end
	end

endmodule

`default_nettype wire

//--- design/fix_session_top.sv
//////////////////////////////////////////////////
// FIX session layer top
// config table, session machine and launcher
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fix_session_top
	import fix_session_pkg::*;
(
	input  wire logic      clk,
	input  wire logic      rst,

	// host configuration
	input  wire logic      cfg_we_i,
	input  wire host_t     cfg_host_i,
	input  wire comp_id_t  cfg_comp_id_i,
	input  wire comp_len_t cfg_comp_len_i,
	input  wire logic      cfg_initiator_i,

	// events from receive processor, TCP engine and timers
	input  wire logic      new_message_i,
	input  wire msg_code_t msg_type_i,
	input  wire validity_t validity_i,
	input  wire logic      connected_i,
	input  wire logic      end_session_i,
	input  wire logic      timeout_i,
	input  wire logic      resend_done_i,
	input  wire host_t     host_i,

	input  wire logic      msg_busy_i,

	output logic           disconnect_o,
	output host_t          disconnect_host_o,
	output logic           ignore_o,
	output logic           update_seq_o,
	output host_t          seq_host_o,

	// to the message builder
	output logic           initiate_msg_o,
	output msg_code_t      msg_code_o,
	output comp_id_t       target_comp_id_o,
	output comp_len_t      target_comp_len_o,
	output logic           launch_drop_o
);

	host_t     role_host;
	logic      role_initiator;
	host_t     head_host;
	comp_id_t  head_comp_id;
	comp_len_t head_comp_len;

	logic      req_valid;
	host_t     req_host;
	msg_code_t req_code;

	host_config_table i_host_cfg (
		.clk              (clk),
		.rst              (rst),
		.cfg_we_i         (cfg_we_i),
		.cfg_host_i       (cfg_host_i),
		.cfg_comp_id_i    (cfg_comp_id_i),
		.cfg_comp_len_i   (cfg_comp_len_i),
		.cfg_initiator_i  (cfg_initiator_i),
		.rd_a_host_i      (role_host),
		.rd_a_initiator_o (role_initiator),
		.rd_b_host_i      (head_host),
		.rd_b_comp_id_o   (head_comp_id),
		.rd_b_comp_len_o  (head_comp_len)
	);

	session_fsm i_session (
		.clk               (clk),
		.rst               (rst),
		.new_message_i     (new_message_i),
		.msg_type_i        (msg_type_i),
		.validity_i        (validity_i),
		.connected_i       (connected_i),
		.end_session_i     (end_session_i),
		.timeout_i         (timeout_i),
		.resend_done_i     (resend_done_i),
		.host_i            (host_i),
		.cfg_host_o        (role_host),
		.cfg_initiator_i   (role_initiator),
		.disconnect_o      (disconnect_o),
		.disconnect_host_o (disconnect_host_o),
		.ignore_o          (ignore_o),
		.update_seq_o      (update_seq_o),
		.seq_host_o        (seq_host_o),
		.req_valid_o       (req_valid),
		.req_host_o        (req_host),
		.req_code_o        (req_code)
	);

	message_launcher i_launcher (
		.clk               (clk),
		.rst               (rst),
		.req_valid_i       (req_valid),
		.req_host_i        (req_host),
		.req_code_i        (req_code),
		.msg_busy_i        (msg_busy_i),
		.cfg_host_o        (head_host),
		.cfg_comp_id_i     (head_comp_id),
		.cfg_comp_len_i    (head_comp_len),
		.initiate_msg_o    (initiate_msg_o),
		.msg_code_o        (msg_code_o),
		.target_comp_id_o  (target_comp_id_o),
		.target_comp_len_o (target_comp_len_o),
		.launch_drop_o     (launch_drop_o)
	);

endmodule

`default_nettype wire

//--- testbench/tb_session_model.svh
//////////////////////////////////////////////////
// session reference model
// transition table, config mirror and the orders
// the launcher is expected to issue
//////////////////////////////////////////////////

`ifndef TB_SESSION_MODEL_SVH
`define TB_SESSION_MODEL_SVH

// event kinds
localparam int EV_MSG   = 0;
localparam int EV_CONN  = 1;
localparam int EV_END   = 2;
localparam int EV_TMO   = 3;
localparam int EV_RDONE = 4;

typedef struct packed {
	msg_code_t code;
	comp_id_t  comp_id;
	comp_len_t comp_len;
} order_t;

session_state_e model_state [`FIX_NUM_HOSTS];
comp_id_t       cfg_id_m    [`FIX_NUM_HOSTS];
comp_len_t      cfg_len_m   [`FIX_NUM_HOSTS];
bit             cfg_init_m  [`FIX_NUM_HOSTS];

order_t exp_q [$];      // orders not yet issued, oldest first
int     drop_pending;   // requests that should overflow the queue

function automatic void next_state_and_action(
	input  session_state_e cur,
	input  int             kind,
	input  msg_code_t      mtype,
	input  validity_t      val,
	input  bit             initiator,
	output session_state_e nxt,
	output bit             dis,
	output bit             ign,
	output bit             upd,
	output bit             send,
	output msg_code_t      code
);
	bit good;
	bit ahead;
	bit is_logon;
	bit is_logout;
	good      = (val == `FIX_VAL_VALID);
	ahead     = (val == `FIX_VAL_SEQ_HIGH);
	is_logon  = (mtype == `FIX_MSG_LOGON);
	is_logout = (mtype == `FIX_MSG_LOGOUT);
	nxt  = cur;
	dis  = 1'b0;
	ign  = 1'b0;
	upd  = 1'b0;
	send = 1'b0;
	code = `FIX_MSG_APP;
	case (kind)
		EV_CONN: begin
			send = initiator;
			code = `FIX_MSG_LOGON;
			nxt  = initiator ? SES_LOGON_SENT : SES_CONNECTED;
		end
		EV_END: begin
			send = 1'b1;
			code = `FIX_MSG_LOGOUT;
			nxt  = SES_LOGOUT_SENT;
		end
		EV_TMO: begin
			if (cur == SES_LOGON_SENT || cur == SES_LOGOUT_SENT || cur == SES_HEARTBEAT_SENT) begin
				dis = 1'b1;
			end else if (cur != SES_DISCONNECTED) begin
				send = 1'b1;
				code = `FIX_MSG_HEARTBEAT;
				nxt  = SES_HEARTBEAT_SENT;
			end
		end
		EV_RDONE: begin
			if (cur == SES_RESEND_SENT) nxt = SES_NORMAL;
			if (cur == SES_RESEND_LOGOUT) begin
				send = 1'b1;
				code = `FIX_MSG_LOGOUT;
				nxt  = SES_LOGOUT_SENT;
			end
		end
		default: begin
			// incoming message, a closed session takes no notice
			if (cur == SES_DISCONNECTED) begin
				nxt = cur;
			end else if (val == `FIX_VAL_SEQ_LOW || val == `FIX_VAL_INVALID) begin
				dis = 1'b1;
			end else if (val == `FIX_VAL_GARBLED) begin
				ign = 1'b1;
			end else if (cur == SES_CONNECTED) begin
				send = good && is_logon;
				code = `FIX_MSG_LOGON;
				dis  = !(good && is_logon);
				nxt  = SES_NORMAL;
			end else if (cur == SES_LOGON_SENT) begin
				if (is_logon && good) begin
					nxt = SES_NORMAL;
				end else if (is_logon && ahead) begin
					send = 1'b1;
					code = `FIX_MSG_RESEND_REQ;
					nxt  = SES_RESEND_SENT;
				end else begin
					dis = 1'b1;
				end
			end else if (cur == SES_NORMAL || cur == SES_HEARTBEAT_SENT) begin
				if (is_logout && good) begin
					send = 1'b1;
					code = `FIX_MSG_LOGOUT;
					dis  = 1'b1;
				end else if (ahead) begin
					send = 1'b1;
					code = `FIX_MSG_RESEND_REQ;
					nxt  = is_logout ? SES_RESEND_LOGOUT : SES_RESEND_SENT;
				end else if (mtype == `FIX_MSG_HEARTBEAT) begin
					send = 1'b1;
					code = `FIX_MSG_HEARTBEAT;
					nxt  = SES_HEARTBEAT_SENT;
				end else begin
					nxt = SES_NORMAL;
				end
			end else if (cur == SES_LOGOUT_SENT) begin
				dis = 1'b1;
			end else if (mtype == `FIX_MSG_GAP_FILL || mtype == `FIX_MSG_SEQ_RESET) begin
				upd = 1'b1;   // resend states from here on
			end else if (ahead) begin
				send = 1'b1;
				code = `FIX_MSG_RESEND_REQ;
			end
		end
	endcase
	if (dis) nxt = SES_DISCONNECTED;
endfunction

// an order lands in the queue unless the launcher is already full
function automatic void expect_order(input host_t h, input msg_code_t code);
	order_t o;
	o.code     = code;
	o.comp_id  = cfg_id_m[h];
	o.comp_len = cfg_len_m[h];
	if (exp_q.size() >= `FIX_LAUNCH_DEPTH) begin
		drop_pending++;
	end else begin
		exp_q.push_back(o);
	end
endfunction

`endif

//--- testbench/tb_fix_session.sv
//////////////////////////////////////////////////
// testbench for the FIX session layer
// drives config and session events, checks the
// action strobes and issued orders by assertions
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "fix_session_macros.svh"

module tb_fix_session
	import fix_session_pkg::*;
();

	logic      clk;
	logic      rst;
	logic      cfg_we;
	host_t     cfg_host;
	comp_id_t  cfg_comp_id;
	comp_len_t cfg_comp_len;
	logic      cfg_initiator;
	logic      new_message;
	msg_code_t msg_type;
	validity_t validity;
	logic      connected;
	logic      end_session;
	logic      timeout;
	logic      resend_done;
	host_t     host;
	logic      msg_busy;

	logic      disconnect;
	host_t     disconnect_host;
	logic      ignore;
	logic      update_seq;
	host_t     seq_host;
	logic      initiate_msg;
	msg_code_t msg_code;
	comp_id_t  target_comp_id;
	comp_len_t target_comp_len;
	logic      launch_drop;

	`include "tb_session_model.svh"

	// predicted strobes set with the event and moved to exp_* at the sampling edge
	logic  ev_dis;
	logic  ev_ign;
	logic  ev_upd;
	host_t ev_host;
	logic  exp_dis;
	logic  exp_ign;
	logic  exp_upd;
	host_t exp_host;

	logic [31:0] lcg_state = 32'h43cc;
	int          errors = 0;
	int          test_err_start = 0;
	int          tests_run = 0;
	int          orders_issued = 0;
	int          ctrl_high_cycles = 0;
	int          cycle_cnt = 0;
	int          last_event_cycle = 0;
	int          last_issue_cycle = 0;
	int          issue_cycles [$];

	fix_session_top i_dut (
		.clk               (clk),
		.rst               (rst),
		.cfg_we_i          (cfg_we),
		.cfg_host_i        (cfg_host),
		.cfg_comp_id_i     (cfg_comp_id),
		.cfg_comp_len_i    (cfg_comp_len),
		.cfg_initiator_i   (cfg_initiator),
		.new_message_i     (new_message),
		.msg_type_i        (msg_type),
		.validity_i        (validity),
		.connected_i       (connected),
		.end_session_i     (end_session),
		.timeout_i         (timeout),
		.resend_done_i     (resend_done),
		.host_i            (host),
		.msg_busy_i        (msg_busy),
		.disconnect_o      (disconnect),
		.disconnect_host_o (disconnect_host),
		.ignore_o          (ignore),
		.update_seq_o      (update_seq),
		.seq_host_o        (seq_host),
		.initiate_msg_o    (initiate_msg),
		.msg_code_o        (msg_code),
		.target_comp_id_o  (target_comp_id),
		.target_comp_len_o (target_comp_len),
		.launch_drop_o     (launch_drop)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		#500us;
		$display("simulation ran out of time, a wait never returned");
		$display("*** TEST FAILED ***");
		$finish;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		exp_dis   <= ev_dis;
		exp_ign   <= ev_ign;
		exp_upd   <= ev_upd;
		exp_host  <= ev_host;
	end

	// outputs are read at the falling edge and the queue updates 1 ns later
	always @(negedge clk) begin
		if (!rst && (disconnect || ignore || update_seq || initiate_msg || launch_drop))
			ctrl_high_cycles++;
		if (!rst && initiate_msg) begin
			issue_cycles.push_back(cycle_cnt);
			last_issue_cycle = cycle_cnt;
			orders_issued++;
		end
		#1;
		if (!rst && initiate_msg && exp_q.size() > 0) exp_q.delete(0);
		if (!rst && launch_drop && drop_pending > 0) drop_pending--;
	end

	function automatic bit order_matches();
		if (exp_q.size() == 0) return 1'b0;
		return msg_code == exp_q[0].code && target_comp_id == exp_q[0].comp_id &&
			target_comp_len == exp_q[0].comp_len;
	endfunction

	check_order: assert property (@(negedge clk) disable iff (rst)
		!initiate_msg || order_matches())
		else begin
			if (exp_q.size() == 0)
				$display("unexpected order with code %0h at %0t, none was pending",
					msg_code, $time);
			else
				$display("Mismatch at %0t: order %0h id %h len %0d, expected %0h id %h len %0d",
					$time, msg_code, target_comp_id, target_comp_len,
					exp_q[0].code, exp_q[0].comp_id, exp_q[0].comp_len);
			errors++;
		end

	check_disconnect: assert property (@(negedge clk) disable iff (rst)
		disconnect == exp_dis && (!exp_dis || disconnect_host == exp_host))
		else begin
			$display("Mismatch at %0t: disconnect %0b host %0d, expected %0b host %0d",
				$time, disconnect, disconnect_host, exp_dis, exp_host);
			errors++;
		end

	check_ignore: assert property (@(negedge clk) disable iff (rst) ignore == exp_ign)
		else begin
			$display("Mismatch at %0t: ignore %0b, expected %0b", $time, ignore, exp_ign);
			errors++;
		end

	check_update_seq: assert property (@(negedge clk) disable iff (rst)
		update_seq == exp_upd && (!exp_upd || seq_host == exp_host))
		else begin
			$display("Mismatch at %0t: update_seq %0b host %0d, expected %0b host %0d",
				$time, update_seq, seq_host, exp_upd, exp_host);
			errors++;
		end

	check_drop: assert property (@(negedge clk) disable iff (rst)
		!launch_drop || drop_pending > 0)
		else begin
			$display("launch_drop pulsed at %0t with room left in the queue", $time);
			errors++;
		end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic msg_code_t pick_msg_type(input logic [2:0] sel);
		case (sel)
			3'd0: return `FIX_MSG_LOGON;
			3'd1: return `FIX_MSG_LOGOUT;
			3'd2: return `FIX_MSG_HEARTBEAT;
			3'd3: return `FIX_MSG_RESEND_REQ;
			3'd4: return `FIX_MSG_GAP_FILL;
			3'd5: return `FIX_MSG_SEQ_RESET;
			default: return `FIX_MSG_APP;
		endcase
	endfunction

	task automatic write_config(input host_t h, input bit initiator);
		logic [31:0] r_hi;
		logic [31:0] r_lo;
		r_hi = next_random();
		r_lo = next_random();
		@(posedge clk);
		#1;
		cfg_we        = 1'b1;
		cfg_host      = h;
		cfg_comp_id   = {r_hi, r_lo};
		cfg_comp_len  = comp_len_t'(r_lo[2:0]) + 4'd1;
		cfg_initiator = initiator;
		cfg_id_m[h]   = cfg_comp_id;
		cfg_len_m[h]  = cfg_comp_len;
		cfg_init_m[h] = initiator;
		@(posedge clk);
		#1;
		cfg_we = 1'b0;
	endtask

	// one-cycle event pulse whose effects the model predicts
	task automatic apply_event(input int kind, input host_t h, input msg_code_t mtype,
		input validity_t val);
		session_state_e nxt;
		bit             dis;
		bit             ign;
		bit             upd;
		bit             send;
		msg_code_t      code;
		@(posedge clk);
		#1;
		next_state_and_action(model_state[h], kind, mtype, val, cfg_init_m[h],
			nxt, dis, ign, upd, send, code);
		model_state[h] = nxt;
		if (send) expect_order(h, code);
		last_event_cycle = cycle_cnt;
		host        = h;
		msg_type    = mtype;
		validity    = val;
		new_message = (kind == EV_MSG);
		connected   = (kind == EV_CONN);
		end_session = (kind == EV_END);
		timeout     = (kind == EV_TMO);
		resend_done = (kind == EV_RDONE);
		ev_dis  = dis;
		ev_ign  = ign;
		ev_upd  = upd;
		ev_host = h;
		@(posedge clk);
		#1;
		new_message = 1'b0;
		connected   = 1'b0;
		end_session = 1'b0;
		timeout     = 1'b0;
		resend_done = 1'b0;
		ev_dis = 1'b0;
		ev_ign = 1'b0;
		ev_upd = 1'b0;
	endtask

	// connect and exchange logons until the host is in a normal session
	task automatic bring_up(input host_t h);
		apply_event(EV_CONN, h, `FIX_MSG_APP, `FIX_VAL_VALID);
		apply_event(EV_MSG, h, `FIX_MSG_LOGON, `FIX_VAL_VALID);
	endtask

	task automatic wait_drained(input int max_cycles);
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < max_cycles) begin
			@(posedge clk);
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("timed out at %0t with %0d orders never issued", $time, exp_q.size());
			errors++;
		end
		repeat (2) @(posedge clk);   // let trailing strobes pass the checks
	endtask

	task automatic wait_drops(input int max_cycles);
		int n;
		n = 0;
		while (drop_pending != 0 && n < max_cycles) begin
			@(posedge clk);
			n++;
		end
		if (drop_pending != 0) begin
			$display("timed out at %0t waiting for launch_drop", $time);
			errors++;
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		$display("test %0d %s: %0d errors", tests_run, name, errors - test_err_start);
		test_err_start = errors;
	endtask

	initial begin
		int          seen;
		logic [31:0] r;
		rst           = 1'b1;
		cfg_we        = 1'b0;
		cfg_host      = '0;
		cfg_comp_id   = '0;
		cfg_comp_len  = '0;
		cfg_initiator = 1'b0;
		new_message   = 1'b0;
		msg_type      = `FIX_MSG_APP;
		validity      = `FIX_VAL_VALID;
		connected     = 1'b0;
		end_session   = 1'b0;
		timeout       = 1'b0;
		resend_done   = 1'b0;
		host          = '0;
		msg_busy      = 1'b0;
		ev_dis        = 1'b0;
		ev_ign        = 1'b0;
		ev_upd        = 1'b0;
		ev_host       = '0;
		drop_pending  = 0;
		for (int h = 0; h < `FIX_NUM_HOSTS; h++) begin
			model_state[h] = SES_DISCONNECTED;
			cfg_id_m[h]    = '0;
			cfg_len_m[h]   = '0;
			cfg_init_m[h]  = 1'b0;
		end
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;

		// even hosts open their sessions and odd hosts wait for the peer
		for (int h = 0; h < `FIX_NUM_HOSTS; h++)
			write_config(host_t'(h), (h % 2) == 0);

		// closed sessions stay silent after reset
		seen = ctrl_high_cycles;
		for (int i = 0; i < 10; i++) begin
			r = next_random();
			apply_event(EV_MSG, host_t'(r[18:16]), pick_msg_type(r[2:0]),
				validity_t'(r[15:8] % 8'd5));
		end
		repeat (2) @(posedge clk);
		assert (ctrl_high_cycles == seen)
			else begin
				$display("Mismatch at %0t: control outputs high in %0d cycles, expected none",
					$time, ctrl_high_cycles - seen);
				errors++;
			end
		finish_test("quiet after reset");

		// initiator sends logon at once while the acceptor waits for the peer
		apply_event(EV_CONN, 3'd0, `FIX_MSG_APP, `FIX_VAL_VALID);
		wait_drained(20);
		assert (last_issue_cycle - last_event_cycle - 1 == 2)
			else begin
				$display("Mismatch at %0t: logon issued %0d cycles after connect, expected 2",
					$time, last_issue_cycle - last_event_cycle - 1);
				errors++;
			end
		apply_event(EV_MSG, 3'd0, `FIX_MSG_LOGON, `FIX_VAL_VALID);
		seen = orders_issued;
		apply_event(EV_CONN, 3'd1, `FIX_MSG_APP, `FIX_VAL_VALID);
		repeat (6) @(posedge clk);
		assert (orders_issued == seen)
			else begin
				$display("Mismatch at %0t: acceptor issued an order before the peer logon",
					$time);
				errors++;
			end
		apply_event(EV_MSG, 3'd1, `FIX_MSG_LOGON, `FIX_VAL_VALID);
		wait_drained(20);
		finish_test("logon role");

		// message rules in a normal session
		apply_event(EV_MSG, 3'd0, `FIX_MSG_HEARTBEAT, `FIX_VAL_VALID);
		apply_event(EV_MSG, 3'd0, `FIX_MSG_APP, `FIX_VAL_VALID);
		apply_event(EV_MSG, 3'd1, `FIX_MSG_APP, `FIX_VAL_GARBLED);
		apply_event(EV_MSG, 3'd1, `FIX_MSG_APP, `FIX_VAL_SEQ_HIGH);
		apply_event(EV_RDONE, 3'd1, `FIX_MSG_APP, `FIX_VAL_VALID);
		apply_event(EV_MSG, 3'd0, `FIX_MSG_APP, `FIX_VAL_SEQ_LOW);
		apply_event(EV_MSG, 3'd1, `FIX_MSG_LOGOUT, `FIX_VAL_VALID);
		wait_drained(20);
		finish_test("normal session rules");

		// logout with a gap waits for the resend first
		bring_up(3'd3);
		apply_event(EV_MSG, 3'd3, `FIX_MSG_LOGOUT, `FIX_VAL_SEQ_HIGH);
		apply_event(EV_MSG, 3'd3, `FIX_MSG_GAP_FILL, `FIX_VAL_VALID);
		apply_event(EV_RDONE, 3'd3, `FIX_MSG_APP, `FIX_VAL_VALID);
		apply_event(EV_MSG, 3'd3, `FIX_MSG_LOGOUT, `FIX_VAL_VALID);
		wait_drained(20);
		finish_test("resend cycle");

		// heartbeat on the first timeout and drop on the second
		bring_up(3'd4);
		apply_event(EV_TMO, 3'd4, `FIX_MSG_APP, `FIX_VAL_VALID);
		apply_event(EV_TMO, 3'd4, `FIX_MSG_APP, `FIX_VAL_VALID);
		// an unanswered logout also ends on a timeout
		bring_up(3'd4);
		apply_event(EV_END, 3'd4, `FIX_MSG_APP, `FIX_VAL_VALID);
		apply_event(EV_TMO, 3'd4, `FIX_MSG_APP, `FIX_VAL_VALID);
		wait_drained(20);
		finish_test("timeouts");

		// four orders queue behind a busy builder and the fifth overflows
		bring_up(3'd0);
		bring_up(3'd1);
		bring_up(3'd2);
		bring_up(3'd5);
		bring_up(3'd6);
		wait_drained(40);
		@(posedge clk);
		#1;
		msg_busy = 1'b1;
		apply_event(EV_TMO, 3'd0, `FIX_MSG_APP, `FIX_VAL_VALID);
		apply_event(EV_TMO, 3'd1, `FIX_MSG_APP, `FIX_VAL_VALID);
		apply_event(EV_TMO, 3'd2, `FIX_MSG_APP, `FIX_VAL_VALID);
		apply_event(EV_TMO, 3'd5, `FIX_MSG_APP, `FIX_VAL_VALID);
		apply_event(EV_TMO, 3'd6, `FIX_MSG_APP, `FIX_VAL_VALID);
		wait_drops(20);
		repeat (4) @(posedge clk);
		issue_cycles.delete();
		#1;
		msg_busy = 1'b0;
		wait_drained(20);
		assert (issue_cycles.size() == 4 && issue_cycles[3] - issue_cycles[0] == 3)
			else begin
				$display("Mismatch at %0t: %0d orders after release, expected 4 back to back",
					$time, issue_cycles.size());
				errors++;
			end
		finish_test("back-pressure");

		repeat (4) @(posedge clk);
		if (drop_pending != 0 || exp_q.size() != 0) begin
			$display("model left %0d drops and %0d orders unmatched", drop_pending, exp_q.size());
			errors++;
		end
		$display("%0d tests, %0d orders issued, %0d errors", tests_run, orders_issued, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- fix_session_top.f
+incdir+design
+incdir+testbench
design/fix_session_pkg.sv
design/host_config_table.sv
design/session_fsm.sv
design/message_launcher.sv
design/fix_session_top.sv
testbench/tb_fix_session.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the FIX session layer testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_fix_session \
	-f fix_session_top.f \
	-o tb_fix_session

./obj_dir/tb_fix_session | tee sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
	echo "simulation reported failure"
	exit 1
fi

if ! grep -qF '*** TEST PASSED ***' sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
